//--- filelist.f
logic/mapper_pkg.sv
logic/bank_regs.sv
logic/vrc_irq_counter.sv
logic/addr_translate.sv
logic/state_readback.sv
logic/mapper_252.sv
verif/m2_clock_gen.sv
verif/mapper_252_tb.sv

//--- logic/addr_translate.sv
`timescale 1ns/1ps

module addr_translate import mapper_pkg::*; (
	input  logic [14:0]           cpu_addr,
	input  logic                  cpu_rw,
	input  logic                  cpu_ce,
	input  logic                  m2,
	input  logic [13:0]           ppu_addr,
	input  logic                  ppu_oe,
	input  logic                  ppu_we,
	input  logic                  cfg_mir_v,
	input  logic [BANK_W-1:0]     prg_bank0,
	input  logic [BANK_W-1:0]     prg_bank1,
	input  logic [BANK_W-1:0]     chr_bank [0:CHR_BANKS-1],
	output logic [PRG_ADDR_W-1:0] prg_addr,
	output logic [CHR_ADDR_W-1:0] chr_addr,
	output logic [12:0]           srm_addr,
	output logic                  prg_oe,
	output logic                  chr_oe,
	output logic                  rom_ce,
	output logic                  ram_ce,
	output logic                  ram_we,
	output logic                  chr_ce,
	output logic                  chr_we,
	output logic                  ciram_a10,
	output logic                  ciram_ce
);

	always_comb begin
		prg_addr[12:0] = cpu_addr[12:0];
		if (cpu_ce) begin
			prg_addr[PRG_ADDR_W-1:13] = '0;
		end else begin
			case (cpu_addr[14:13])
				2'd0: prg_addr[PRG_ADDR_W-1:13] = prg_bank0[PRG_ADDR_W-14:0];
				2'd1: prg_addr[PRG_ADDR_W-1:13] = prg_bank1[PRG_ADDR_W-14:0];
				// Top 16 KB is fixed to the last two pages
				default: prg_addr[PRG_ADDR_W-1:13] = {{(PRG_ADDR_W-14){1'b1}}, cpu_addr[13]};
			endcase
		end
	end

	assign chr_addr = {chr_bank[ppu_addr[12:10]], ppu_addr[9:0]};
	assign srm_addr = cpu_addr[12:0];

	assign prg_oe = cpu_rw;
	assign chr_oe = !ppu_oe;
	assign rom_ce = !cpu_ce;
	assign ram_ce = (cpu_addr[14:13] == 2'b11) && cpu_ce && m2;
	assign ram_we = ram_ce && !cpu_rw;

	// Vertical mirroring takes A10, horizontal takes A11
	assign ciram_a10 = cfg_mir_v ? ppu_addr[10] : ppu_addr[11];
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce = ciram_ce;
	assign chr_we = !ppu_we && ciram_ce;

endmodule

//--- logic/bank_regs.sv
`timescale 1ns/1ps

module bank_regs import mapper_pkg::*; (
	input  logic              m2,
	input  logic              arst_n,
	input  logic [14:0]       cpu_addr,
	input  logic [7:0]        cpu_dat,
	input  logic              cpu_rw,
	input  logic              cpu_ce,
	input  logic              ss_act,
	input  logic              ss_we,
	input  logic [7:0]        ss_addr,
	output logic [BANK_W-1:0] prg_bank0,
	output logic [BANK_W-1:0] prg_bank1,
	output logic [BANK_W-1:0] chr_bank [0:CHR_BANKS-1]
);

	logic [BANK_W-1:0] prg_bank [PRG_BANKS];
	logic [BANK_W-1:0] chr_reg [CHR_BANKS];
	logic              cpu_wr;
	logic [2:0]        reg_sel;
	logic              chr_sel;
	logic [1:0]        chr_pair;
	logic [2:0]        chr_idx;
	logic              ss_chr_sel;
	logic              ss_prg_sel;

	assign cpu_wr = !cpu_ce && !cpu_rw;
	assign reg_sel = cpu_addr[14:12];
	assign chr_sel = (reg_sel >= REG_CHR_FIRST) && (reg_sel <= REG_CHR_LAST);

	// Each code 011..110 covers a pair of banks, cpu_addr[3] picks one of them
	assign chr_pair = 2'(reg_sel - REG_CHR_FIRST);
	assign chr_idx = {chr_pair, cpu_addr[3]};

	assign ss_chr_sel = ss_addr[7:3] == SS_CHR_BASE[7:3];
	assign ss_prg_sel = ss_addr[7:1] == SS_PRG_BASE[7:1];

	always_ff @(negedge m2 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < PRG_BANKS; i++) begin
				prg_bank[i] <= '0;
			end
			for (int i = 0; i < CHR_BANKS; i++) begin
				chr_reg[i] <= '0;
			end
		end else if (ss_act) begin
			if (ss_we && ss_chr_sel) begin
				chr_reg[ss_addr[2:0]] <= cpu_dat;
			end
			if (ss_we && ss_prg_sel) begin
				prg_bank[ss_addr[0]] <= cpu_dat;
			end
		end else if (cpu_wr) begin
			if (reg_sel == REG_PRG0) begin
				prg_bank[0] <= cpu_dat;
			end
			if (reg_sel == REG_PRG1) begin
				prg_bank[1] <= cpu_dat;
			end
			// CHR banks are loaded one nibble at a time from cpu_dat[3:0]
			if (chr_sel && !cpu_addr[2]) begin
				chr_reg[chr_idx][3:0] <= cpu_dat[3:0];
			end
			if (chr_sel && cpu_addr[2]) begin
				chr_reg[chr_idx][7:4] <= cpu_dat[3:0];
			end
		end
	end

	assign prg_bank0 = prg_bank[0];
	assign prg_bank1 = prg_bank[1];

	always_comb begin
		for (int i = 0; i < CHR_BANKS; i++) begin
			chr_bank[i] = chr_reg[i];
		end
	end

	a_ss_we_in_ss_mode: assert property (
		@(negedge m2) disable iff (!arst_n)
		ss_we |-> ss_act
	) else $error("save-state write strobe seen outside save-state mode");

endmodule

//--- logic/mapper_252.sv
`timescale 1ns/1ps

module mapper_252 import mapper_pkg::*; (
	input  logic                  m2,
	input  logic                  arst_n,
	input  logic [14:0]           cpu_addr,
	input  logic [7:0]            cpu_dat,
	input  logic                  cpu_rw,
	input  logic                  cpu_ce,
	input  logic [13:0]           ppu_addr,
	input  logic                  ppu_oe,
	input  logic                  ppu_we,
	input  logic                  cfg_mir_v,
	input  logic                  ss_act,
	input  logic                  ss_we,
	input  logic [7:0]            ss_addr,
	output logic [PRG_ADDR_W-1:0] prg_addr,
	output logic [CHR_ADDR_W-1:0] chr_addr,
	output logic [12:0]           srm_addr,
	output logic                  prg_oe,
	output logic                  chr_oe,
	output logic                  rom_ce,
	output logic                  ram_ce,
	output logic                  ram_we,
	output logic                  chr_ce,
	output logic                  chr_we,
	output logic                  ciram_a10,
	output logic                  ciram_ce,
	output logic                  irq,
	output logic [7:0]            ss_rdat
);

	logic [BANK_W-1:0] prg_bank0;
	logic [BANK_W-1:0] prg_bank1;
	logic [BANK_W-1:0] chr_bank [0:CHR_BANKS-1];
	logic [7:0]        irq_ss_rdat;

	bank_regs u_bank_regs (
		.m2        (m2),
		.arst_n    (arst_n),
		.cpu_addr  (cpu_addr),
		.cpu_dat   (cpu_dat),
		.cpu_rw    (cpu_rw),
		.cpu_ce    (cpu_ce),
		.ss_act    (ss_act),
		.ss_we     (ss_we),
		.ss_addr   (ss_addr),
		.prg_bank0 (prg_bank0),
		.prg_bank1 (prg_bank1),
		.chr_bank  (chr_bank)
	);

	vrc_irq_counter u_irq (
		.m2          (m2),
		.arst_n      (arst_n),
		.cpu_addr    (cpu_addr),
		.cpu_dat     (cpu_dat),
		.cpu_rw      (cpu_rw),
		.cpu_ce      (cpu_ce),
		.ss_act      (ss_act),
		.ss_we       (ss_we),
		.ss_addr     (ss_addr),
		.irq         (irq),
		.irq_ss_rdat (irq_ss_rdat)
	);

	addr_translate u_addr_translate (
		.cpu_addr  (cpu_addr),
		.cpu_rw    (cpu_rw),
		.cpu_ce    (cpu_ce),
		.m2        (m2),
		.ppu_addr  (ppu_addr),
		.ppu_oe    (ppu_oe),
		.ppu_we    (ppu_we),
		.cfg_mir_v (cfg_mir_v),
		.prg_bank0 (prg_bank0),
		.prg_bank1 (prg_bank1),
		.chr_bank  (chr_bank),
		.prg_addr  (prg_addr),
		.chr_addr  (chr_addr),
		.srm_addr  (srm_addr),
		.prg_oe    (prg_oe),
		.chr_oe    (chr_oe),
		.rom_ce    (rom_ce),
		.ram_ce    (ram_ce),
		.ram_we    (ram_we),
		.chr_ce    (chr_ce),
		.chr_we    (chr_we),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

	state_readback u_state_readback (
		.ss_addr     (ss_addr),
		.prg_bank0   (prg_bank0),
		.prg_bank1   (prg_bank1),
		.chr_bank    (chr_bank),
		.irq_ss_rdat (irq_ss_rdat),
		.ss_rdat     (ss_rdat)
	);

endmodule

//--- logic/mapper_pkg.sv
package mapper_pkg;

	localparam logic [7:0] MAP_IDX = 8'd252;

	localparam int PRG_BANKS = 2;
	localparam int CHR_BANKS = 8;
	localparam int BANK_W = 8;
	localparam int PRG_ADDR_W = 19;
	localparam int CHR_ADDR_W = 18;

	// Prescaler runs 341 -> 2 in steps of 3, one scanline per lap
	localparam int IRQ_PRE_W = 9;
	localparam logic [IRQ_PRE_W-1:0] IRQ_PRESCALE_LOAD = 9'd341;
	localparam logic [IRQ_PRE_W-1:0] IRQ_PRESCALE_STEP = 9'd3;
	localparam logic [IRQ_PRE_W-1:0] IRQ_PRESCALE_HIT = 9'd2;

	// CPU register map, selected by cpu_addr[14:12]
	localparam logic [2:0] REG_PRG0 = 3'b000;
	localparam logic [2:0] REG_PRG1 = 3'b010;
	localparam logic [2:0] REG_CHR_FIRST = 3'b011;
	localparam logic [2:0] REG_CHR_LAST = 3'b110;
	localparam logic [2:0] REG_IRQ = 3'b111;

	// IRQ block sub-registers, selected by cpu_addr[3:2]
	localparam logic [1:0] IRQ_SUB_LATCH_LO = 2'b00;
	localparam logic [1:0] IRQ_SUB_LATCH_HI = 2'b01;
	localparam logic [1:0] IRQ_SUB_CTRL = 2'b10;
	localparam logic [1:0] IRQ_SUB_ACK = 2'b11;

	// Bit positions in a control write
	localparam int CTRL_EN_AFTER = 0;
	localparam int CTRL_EN = 1;
	localparam int CTRL_CYCLE = 2;

	// Save-state address map
	localparam logic [7:0] SS_CHR_BASE = 8'd0;
	localparam logic [7:0] SS_PRG_BASE = 8'd8;
	localparam logic [7:0] SS_IRQ_CTRL = 8'd10;
	localparam logic [7:0] SS_IRQ_CNT = 8'd11;
	localparam logic [7:0] SS_IRQ_LATCH = 8'd12;
	localparam logic [7:0] SS_IRQ_PRE = 8'd13;
	localparam logic [7:0] SS_IDX = 8'd127;
	localparam logic [7:0] SS_EMPTY = 8'hff;

endpackage

//--- logic/state_readback.sv
`timescale 1ns/1ps

module state_readback import mapper_pkg::*; (
	input  logic [7:0]        ss_addr,
	input  logic [BANK_W-1:0] prg_bank0,
	input  logic [BANK_W-1:0] prg_bank1,
	input  logic [BANK_W-1:0] chr_bank [0:CHR_BANKS-1],
	input  logic [7:0]        irq_ss_rdat,
	output logic [7:0]        ss_rdat
);

	always_comb begin
		if (ss_addr[7:3] == SS_CHR_BASE[7:3]) begin
			ss_rdat = chr_bank[ss_addr[2:0]];
		end else if (ss_addr[7:1] == SS_PRG_BASE[7:1]) begin
			ss_rdat = ss_addr[0] ? prg_bank1 : prg_bank0;
		end else if (ss_addr >= SS_IRQ_CTRL && ss_addr <= SS_IRQ_PRE) begin
			// IRQ block serves its own four bytes
			ss_rdat = irq_ss_rdat;
		end else if (ss_addr == SS_IDX) begin
			ss_rdat = MAP_IDX;
		end else begin
			ss_rdat = SS_EMPTY;
		end
	end

endmodule

//--- logic/vrc_irq_counter.sv
`timescale 1ns/1ps

module vrc_irq_counter import mapper_pkg::*; (
	input  logic        m2,
	input  logic        arst_n,
	input  logic [14:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic        cpu_ce,
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	output logic        irq,
	output logic [7:0]  irq_ss_rdat
);

	logic [7:0]           irq_latch;
	logic [7:0]           irq_counter;
	logic [IRQ_PRE_W-1:0] irq_prescaler;
	logic                 irq_enable;
	logic                 irq_enable_after;
	logic                 irq_cycle_mode;
	logic                 irq_wr;
	logic                 latch_lo_wr;
	logic                 latch_hi_wr;
	logic                 ctrl_wr;
	logic                 ack_wr;
	logic                 count_en;
	logic                 tick;

	assign irq_wr = !cpu_ce && !cpu_rw && (cpu_addr[14:12] == REG_IRQ);
	assign latch_lo_wr = irq_wr && (cpu_addr[3:2] == IRQ_SUB_LATCH_LO);
	assign latch_hi_wr = irq_wr && (cpu_addr[3:2] == IRQ_SUB_LATCH_HI);
	assign ctrl_wr = irq_wr && (cpu_addr[3:2] == IRQ_SUB_CTRL);
	assign ack_wr = irq_wr && (cpu_addr[3:2] == IRQ_SUB_ACK);

	// A control write owns the counter on its edge
	assign count_en = irq_enable && !ctrl_wr;
	assign tick = count_en && (irq_cycle_mode || irq_prescaler == IRQ_PRESCALE_HIT);

	always_ff @(negedge m2 or negedge arst_n) begin
		if (!arst_n) begin
			irq <= 1'b0;
			irq_enable <= 1'b0;
			irq_enable_after <= 1'b0;
			irq_cycle_mode <= 1'b0;
		end else if (ss_act) begin
			if (ss_we && ss_addr == SS_IRQ_CTRL) begin
				{irq_enable_after, irq, irq_enable, irq_cycle_mode} <= cpu_dat[7:4];
			end
		end else begin
			if (ctrl_wr) begin
				irq_enable_after <= cpu_dat[CTRL_EN_AFTER];
				irq_enable <= cpu_dat[CTRL_EN];
				irq_cycle_mode <= cpu_dat[CTRL_CYCLE];
				irq <= 1'b0;
			end else if (ack_wr) begin
				irq_enable <= irq_enable_after;
				irq <= 1'b0;
			end
			// A wrap on the same edge as an acknowledge still fires
			if (tick && irq_counter == 8'd0) begin
				irq <= 1'b1;
			end
		end
	end

	always_ff @(negedge m2) begin
		if (ss_act) begin
			if (ss_we) begin
				case (ss_addr)
					SS_IRQ_CTRL: irq_prescaler[IRQ_PRE_W-1] <= cpu_dat[3];
					SS_IRQ_CNT: irq_counter <= cpu_dat;
					SS_IRQ_LATCH: irq_latch <= cpu_dat;
					SS_IRQ_PRE: irq_prescaler[7:0] <= cpu_dat;
					default: ;
				endcase
			end
		end else begin
			if (latch_lo_wr) begin
				irq_latch[3:0] <= cpu_dat[3:0];
			end
			if (latch_hi_wr) begin
				irq_latch[7:4] <= cpu_dat[3:0];
			end
			if (ctrl_wr && cpu_dat[CTRL_EN]) begin
				irq_counter <= irq_latch;
				irq_prescaler <= IRQ_PRESCALE_LOAD;
			end else if (tick) begin
				irq_counter <= (irq_counter == 8'd0) ? irq_latch : irq_counter + 8'd1;
				irq_prescaler <= IRQ_PRESCALE_LOAD;
			end else if (count_en) begin
				irq_prescaler <= irq_prescaler - IRQ_PRESCALE_STEP;
			end
		end
	end

	always_comb begin
		case (ss_addr)
			SS_IRQ_CTRL: irq_ss_rdat = {irq_enable_after, irq, irq_enable, irq_cycle_mode,
				irq_prescaler[IRQ_PRE_W-1], 3'b000};
			SS_IRQ_CNT: irq_ss_rdat = irq_counter;
			SS_IRQ_LATCH: irq_ss_rdat = irq_latch;
			SS_IRQ_PRE: irq_ss_rdat = irq_prescaler[7:0];
			default: irq_ss_rdat = SS_EMPTY;
		endcase
	end

	// From any value on the 341 - 3n ladder the prescaler stays in range
	a_prescaler_range: assert property (
		@(negedge m2) disable iff (!arst_n)
		(!$past(ss_act) && $past(irq_prescaler) <= IRQ_PRESCALE_LOAD &&
			$past(irq_prescaler) % IRQ_PRESCALE_STEP == IRQ_PRESCALE_LOAD % IRQ_PRESCALE_STEP)
		|-> irq_prescaler <= IRQ_PRESCALE_LOAD
	) else $error("IRQ prescaler left its range: %0d", irq_prescaler);

	a_irq_needs_enable: assert property (
		@(negedge m2) disable iff (!arst_n)
		(!$past(ss_act) && $rose(irq)) |-> $past(irq_enable)
	) else $error("irq rose while the counter was disabled");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the mapper 252 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mapper_252_tb -f filelist.f \
	|| { echo "run_sim: build failed"; exit 1; }

out=$(./obj_dir/Vmapper_252_tb)
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || { echo "run_sim: run failed"; exit 1; }

//--- verif/m2_clock_gen.sv
`timescale 1ns/1ps

module m2_clock_gen (
	output logic m2,
	output logic arst_n
);

	localparam int HALF_PERIOD_NS = 50;
	localparam int RESET_CYCLES = 8;

	initial begin
		m2 = 1'b0;
		forever #HALF_PERIOD_NS m2 = !m2;
	end

	// Release lands just after a rising edge, well clear of the falling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge m2);
		#2;
		arst_n = 1'b1;
	end

endmodule

//--- verif/mapper_252_tb.sv
`timescale 1ns/1ps

module mapper_252_tb import mapper_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int BOOT_CYCLES = 20;
	localparam int PRG_CYCLES = 60;
	localparam int CHR_CYCLES = 56;
	localparam int CYC_IRQ_LIMIT = 300;
	localparam int LINE_IRQ_LIMIT = 700;
	localparam int IRQ_OVERHEAD = 16;
	localparam int SS_CYCLES = 90;
	localparam int PLANNED_CYCLES = RESET_CYCLES + BOOT_CYCLES + PRG_CYCLES + CHR_CYCLES +
		CYC_IRQ_LIMIT + LINE_IRQ_LIMIT + 2 * IRQ_OVERHEAD + SS_CYCLES;
	localparam int WATCHDOG_NS = (PLANNED_CYCLES + 100) * 100;

	logic        m2;
	logic        arst_n;
	logic [14:0] cpu_addr;
	logic [7:0]  cpu_dat;
	logic        cpu_rw;
	logic        cpu_ce;
	logic [13:0] ppu_addr;
	logic        ppu_oe;
	logic        ppu_we;
	logic        cfg_mir_v;
	logic        ss_act;
	logic        ss_we;
	logic [7:0]  ss_addr;
	logic [18:0] prg_addr;
	logic [17:0] chr_addr;
	logic [12:0] srm_addr;
	logic        prg_oe;
	logic        chr_oe;
	logic        rom_ce;
	logic        ram_ce;
	logic        ram_we;
	logic        chr_ce;
	logic        chr_we;
	logic        ciram_a10;
	logic        ciram_ce;
	logic        irq;
	logic [7:0]  ss_rdat;

	// Save-state controls for the next cycle
	logic        next_ss_act;
	logic        next_ss_we;
	logic [7:0]  next_ss_addr;

	// Reference model state
	logic [7:0]  m_prg [2];
	logic [7:0]  m_chr [8];
	logic [7:0]  m_latch;
	logic [7:0]  m_cnt;
	logic [8:0]  m_pre;
	logic        m_en;
	logic        m_en_after;
	logic        m_cyc;
	logic        m_irq;

	logic [31:0] lfsr = 32'd77156;
	int          checks = 0;
	int          errors = 0;

	m2_clock_gen u_clk (
		.m2     (m2),
		.arst_n (arst_n)
	);

	mapper_252 DUT (
		.m2        (m2),
		.arst_n    (arst_n),
		.cpu_addr  (cpu_addr),
		.cpu_dat   (cpu_dat),
		.cpu_rw    (cpu_rw),
		.cpu_ce    (cpu_ce),
		.ppu_addr  (ppu_addr),
		.ppu_oe    (ppu_oe),
		.ppu_we    (ppu_we),
		.cfg_mir_v (cfg_mir_v),
		.ss_act    (ss_act),
		.ss_we     (ss_we),
		.ss_addr   (ss_addr),
		.prg_addr  (prg_addr),
		.chr_addr  (chr_addr),
		.srm_addr  (srm_addr),
		.prg_oe    (prg_oe),
		.chr_oe    (chr_oe),
		.rom_ce    (rom_ce),
		.ram_ce    (ram_ce),
		.ram_we    (ram_we),
		.chr_ce    (chr_ce),
		.chr_we    (chr_we),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.irq       (irq),
		.ss_rdat   (ss_rdat)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [14:0] irq_reg_addr(input logic [1:0] sub);
		return {REG_IRQ, 8'(rand_bits(8)), sub, 2'(rand_bits(2))};
	endfunction

	function automatic logic [7:0] model_state_byte(input logic [7:0] a);
		if (a < SS_PRG_BASE) begin
			return m_chr[a[2:0]];
		end else if (a < SS_IRQ_CTRL) begin
			return m_prg[a[0]];
		end else if (a == SS_IRQ_CTRL) begin
			return {m_en_after, m_irq, m_en, m_cyc, m_pre[8], 3'b000};
		end else if (a == SS_IRQ_CNT) begin
			return m_cnt;
		end else if (a == SS_IRQ_LATCH) begin
			return m_latch;
		end else if (a == SS_IRQ_PRE) begin
			return m_pre[7:0];
		end else if (a == SS_IDX) begin
			return MAP_IDX;
		end else begin
			return SS_EMPTY;
		end
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic [18:0] e_prg;
		e_prg[12:0] = cpu_addr[12:0];
		if (cpu_ce) begin
			e_prg[18:13] = '0;
		end else if (cpu_addr[14:13] == 2'd0) begin
			e_prg[18:13] = m_prg[0][5:0];
		end else if (cpu_addr[14:13] == 2'd1) begin
			e_prg[18:13] = m_prg[1][5:0];
		end else begin
			e_prg[18:13] = {5'b11111, cpu_addr[13]};
		end
		expect_eq("prg_addr", 32'(prg_addr), 32'(e_prg));
		expect_eq("chr_addr", 32'(chr_addr), 32'({m_chr[ppu_addr[12:10]], ppu_addr[9:0]}));
		expect_eq("srm_addr", 32'(srm_addr), 32'(cpu_addr[12:0]));
		expect_eq("prg_oe", 32'(prg_oe), 32'(cpu_rw));
		expect_eq("chr_oe", 32'(chr_oe), 32'(!ppu_oe));
		expect_eq("rom_ce", 32'(rom_ce), 32'(!cpu_ce));
		expect_eq("ram_ce", 32'(ram_ce), 32'((cpu_addr[14:13] == 2'b11) && cpu_ce && m2));
		expect_eq("ram_we", 32'(ram_we),
			32'((cpu_addr[14:13] == 2'b11) && cpu_ce && m2 && !cpu_rw));
		expect_eq("ciram_ce", 32'(ciram_ce), 32'(!ppu_addr[13]));
		expect_eq("chr_ce", 32'(chr_ce), 32'(!ppu_addr[13]));
		expect_eq("chr_we", 32'(chr_we), 32'(!ppu_we && !ppu_addr[13]));
		expect_eq("ciram_a10", 32'(ciram_a10), 32'(cfg_mir_v ? ppu_addr[10] : ppu_addr[11]));
		expect_eq("irq", 32'(irq), 32'(m_irq));
		expect_eq("ss_rdat", 32'(ss_rdat), 32'(model_state_byte(ss_addr)));
	endtask

	// Applies one falling edge to the model, from the inputs the DUT samples
	task automatic update_model();
		logic [2:0] sel;
		logic [1:0] pair;
		logic       wr;
		logic       ctrl_wr;
		logic       ack_wr;
		logic       tick;
		logic       wrap;
		sel = cpu_addr[14:12];
		wr = !cpu_ce && !cpu_rw;
		if (ss_act) begin
			if (ss_we && ss_addr < SS_PRG_BASE) begin
				m_chr[ss_addr[2:0]] = cpu_dat;
			end else if (ss_we && ss_addr < SS_IRQ_CTRL) begin
				m_prg[ss_addr[0]] = cpu_dat;
			end else if (ss_we && ss_addr == SS_IRQ_CTRL) begin
				{m_en_after, m_irq, m_en, m_cyc, m_pre[8]} = cpu_dat[7:3];
			end else if (ss_we && ss_addr == SS_IRQ_CNT) begin
				m_cnt = cpu_dat;
			end else if (ss_we && ss_addr == SS_IRQ_LATCH) begin
				m_latch = cpu_dat;
			end else if (ss_we && ss_addr == SS_IRQ_PRE) begin
				m_pre[7:0] = cpu_dat;
			end
		end else begin
			ctrl_wr = wr && sel == 3'd7 && cpu_addr[3:2] == 2'd2;
			ack_wr = wr && sel == 3'd7 && cpu_addr[3:2] == 2'd3;
			tick = m_en && !ctrl_wr && (m_cyc || m_pre == IRQ_PRESCALE_HIT);
			wrap = tick && m_cnt == 8'd0;
			if (ctrl_wr && cpu_dat[1]) begin
				m_cnt = m_latch;
				m_pre = IRQ_PRESCALE_LOAD;
			end else if (tick) begin
				m_cnt = wrap ? m_latch : m_cnt + 8'd1;
				m_pre = IRQ_PRESCALE_LOAD;
			end else if (m_en && !ctrl_wr) begin
				m_pre = m_pre - IRQ_PRESCALE_STEP;
			end
			pair = 2'(sel - 3'd3);
			if (wr && sel == 3'd0) begin
				m_prg[0] = cpu_dat;
			end else if (wr && sel == 3'd2) begin
				m_prg[1] = cpu_dat;
			end else if (wr && sel >= 3'd3 && sel <= 3'd6 && !cpu_addr[2]) begin
				m_chr[{pair, cpu_addr[3]}][3:0] = cpu_dat[3:0];
			end else if (wr && sel >= 3'd3 && sel <= 3'd6) begin
				m_chr[{pair, cpu_addr[3]}][7:4] = cpu_dat[3:0];
			end else if (wr && sel == 3'd7 && cpu_addr[3:2] == 2'd0) begin
				m_latch[3:0] = cpu_dat[3:0];
			end else if (wr && sel == 3'd7 && cpu_addr[3:2] == 2'd1) begin
				m_latch[7:4] = cpu_dat[3:0];
			end
			if (ctrl_wr) begin
				m_en_after = cpu_dat[0];
				m_en = cpu_dat[1];
				m_cyc = cpu_dat[2];
				m_irq = 1'b0;
			end else if (ack_wr) begin
				m_en = m_en_after;
				m_irq = 1'b0;
			end
			if (wrap) begin
				m_irq = 1'b1;
			end
		end
	endtask

	// One m2 period: drive after the rise, check while high and after the fall
	task automatic run_cycle(input logic [14:0] addr, input logic [7:0] dat,
		input logic rw, input logic ce);
		@(posedge m2);
		#5;
		cpu_addr = addr;
		cpu_dat = dat;
		cpu_rw = rw;
		cpu_ce = ce;
		ppu_addr = 14'(rand_bits(14));
		ppu_oe = 1'(rand_bits(1));
		ppu_we = 1'(rand_bits(1));
		cfg_mir_v = 1'(rand_bits(1));
		ss_act = next_ss_act;
		ss_we = next_ss_we;
		ss_addr = next_ss_addr;
		#40;
		check_outputs();
		@(negedge m2);
		update_model();
		#1;
		check_outputs();
	endtask

	task automatic cpu_write(input logic [14:0] addr, input logic [7:0] dat);
		run_cycle(addr, dat, 1'b0, 1'b0);
	endtask

	task automatic cpu_idle();
		run_cycle(15'(rand_bits(15)), 8'(rand_bits(8)), 1'b1, 1'b1);
	endtask

	task automatic irq_run(input logic [7:0] latch, input logic cycle_mode,
		input logic en_after, input int limit, input string mode);
		int n;
		cpu_write(irq_reg_addr(IRQ_SUB_LATCH_LO), {4'(rand_bits(4)), latch[3:0]});
		cpu_write(irq_reg_addr(IRQ_SUB_LATCH_HI), {4'(rand_bits(4)), latch[7:4]});
		cpu_write(irq_reg_addr(IRQ_SUB_CTRL), {5'(rand_bits(5)), cycle_mode, 1'b1, en_after});
		next_ss_addr = SS_IRQ_CTRL;
		n = 0;
		while (!irq && n < limit) begin
			cpu_idle();
			n++;
		end
		checks++;
		assert (irq) else begin
			errors++;
			$display("irq never rose in %s mode within %0d cycles", mode, limit);
		end
		repeat (4) cpu_idle();
		cpu_write(irq_reg_addr(IRQ_SUB_ACK), 8'(rand_bits(8)));
		expect_eq("enable after acknowledge", 32'(ss_rdat[5]), 32'(en_after));
		repeat (6) cpu_idle();
		cpu_write(irq_reg_addr(IRQ_SUB_CTRL), 8'h00);
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic ce_bit;
		cpu_addr = '0;
		cpu_dat = '0;
		cpu_rw = 1'b1;
		cpu_ce = 1'b1;
		ppu_addr = '0;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		cfg_mir_v = 1'b0;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = '0;
		next_ss_act = 1'b0;
		next_ss_we = 1'b0;
		next_ss_addr = '0;
		for (int i = 0; i < 8; i++) begin
			m_chr[i] = '0;
		end
		m_prg[0] = '0;
		m_prg[1] = '0;
		m_latch = '0;
		m_cnt = '0;
		m_pre = '0;
		m_en = 1'b0;
		m_en_after = 1'b0;
		m_cyc = 1'b0;
		m_irq = 1'b0;
		@(posedge arst_n);

		// Reset values, then ROM reads through the fixed banks
		for (int i = 0; i < 10; i++) begin
			next_ss_addr = 8'(i);
			run_cycle(15'(rand_bits(15)), 8'(rand_bits(8)), 1'b1, 1'b0);
			expect_eq("bank after reset", 32'(ss_rdat), 32'd0);
			expect_eq("irq after reset", 32'(irq), 32'd0);
		end
		for (int i = 0; i < BOOT_CYCLES - 10; i++) begin
			run_cycle(15'(rand_bits(15)), 8'(rand_bits(8)), 1'b1, 1'b0);
		end

		for (int i = 0; i < PRG_CYCLES; i++) begin
			next_ss_addr = {7'd4, 1'(rand_bits(1))};
			if (rand_bits(2) == 0) begin
				cpu_write({(rand_bits(1) != 0) ? REG_PRG1 : REG_PRG0, 12'(rand_bits(12))},
					8'(rand_bits(8)));
			end else begin
				ce_bit = 1'(rand_bits(1));
				run_cycle(15'(rand_bits(15)), 8'(rand_bits(8)),
					ce_bit ? 1'(rand_bits(1)) : 1'b1, ce_bit);
			end
		end

		// All 16 CHR nibble registers, then random PPU traffic
		for (int k = 0; k < 16; k++) begin
			cpu_write({3'(3'd3 + 3'(k >> 2)), 8'(rand_bits(8)), 2'(k), 2'(rand_bits(2))},
				8'(rand_bits(8)));
		end
		for (int i = 0; i < CHR_CYCLES - 16; i++) begin
			next_ss_addr = 8'(rand_bits(3));
			cpu_idle();
		end

		irq_run(8'(rand_bits(8)), 1'b1, 1'b0, CYC_IRQ_LIMIT, "cycle");
		irq_run({6'h3f, 2'(rand_bits(2))}, 1'b0, 1'b1, LINE_IRQ_LIMIT, "scanline");

		next_ss_act = 1'b1;
		for (int i = 0; i < 14; i++) begin
			next_ss_addr = 8'(i);
			cpu_idle();
		end
		next_ss_addr = SS_IDX;
		cpu_idle();
		for (int i = 0; i < 6; i++) begin
			next_ss_addr = (i < 4) ? {1'b1, 7'(rand_bits(7))} : 8'(14 + rand_bits(6));
			cpu_idle();
		end
		next_ss_we = 1'b1;
		for (int i = 0; i < 14; i++) begin
			next_ss_addr = 8'(i);
			cpu_idle();
		end
		// Bus writes must not reach any register while ss_act is high
		next_ss_we = 1'b0;
		for (int i = 0; i < 16; i++) begin
			cpu_write(15'(rand_bits(15)), 8'(rand_bits(8)));
		end
		for (int i = 0; i < 14; i++) begin
			next_ss_addr = 8'(i);
			cpu_idle();
		end
		next_ss_act = 1'b0;
		next_ss_addr = SS_IRQ_CTRL;
		repeat (20) cpu_idle();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
